// File: logic/irq_wake_sync.sv
// irq_wake_sync: two-stage interrupt synchronizer with mask, giving the WFI wake request level

`default_nettype none

module irq_wake_sync #(
	parameter int unsigned num_irq = power_pkg::default_num_irq
) (
	input  wire                 clk_always_on,
	input  wire                 rst_n,

	// raw interrupt lines, may come from any clock domain
	input  wire [num_irq-1:0]   irq,
	// per-line enable, already in the clk_always_on domain
	input  wire [num_irq-1:0]   irq_mask,

	// high while any enabled interrupt is pending
	output logic                wfi_wakeup_req
);

	// -------------------------------------------------------------------------
	// synchronizer
	// -------------------------------------------------------------------------

	// first stage may go metastable, only the second stage is used
	logic [num_irq-1:0] irq_meta;
	logic [num_irq-1:0] irq_sync;
	logic [num_irq-1:0] irq_pending;

	// these flops sit on the free-running clock, so interrupts are still
	// sampled while the core clock is gated off
	always_ff @(posedge clk_always_on or negedge rst_n) begin
		if (!rst_n) begin
			irq_meta <= '0;
			irq_sync <= '0;
		end else begin
			irq_meta <= irq;
			irq_sync <= irq_meta;
		end
	end

	// -------------------------------------------------------------------------
	// masking and reduction
	// -------------------------------------------------------------------------

	// the mask is applied after the synchronizer, so enabling a line that is
	// already high raises the request in the same cycle
	assign irq_pending = irq_sync & irq_mask;

	// the request is a level and stays up for as long as the line is held
	// the FSM only looks at it while a WFI or block stall is present
	assign wfi_wakeup_req = |irq_pending;

	// an irq edge shows up here two clk_always_on edges later, which is the
	// whole latency of this block

endmodule

`default_nettype wire

// File: logic/power_csr.sv
// power_csr: policy register for sleep, power down and sleep-on-block, loaded by a write strobe

`default_nettype none

module power_csr (
	input  wire                        clk_always_on,
	input  wire                        rst_n,

	// one-cycle write strobe from the core, with the new policy alongside
	input  wire                        cfg_wr,
	input  wire power_pkg::power_cfg_t cfg_wdata,

	// registered policy, read back by the core and used by the FSM
	output power_pkg::power_cfg_t      cfg
);

	// -------------------------------------------------------------------------
	// write data cleanup
	// -------------------------------------------------------------------------

	power_pkg::power_cfg_t cfg_next;
	logic                  deep_allowed;

	// a deep state exists only if sleep or power down is allowed
	assign deep_allowed = cfg_wdata.allow_sleep | cfg_wdata.allow_power_down;

	// sleep-on-block is stored as zero when there is no deep state to use,
	// so a block stall never targets a state the policy forbids
	always_comb begin
		cfg_next = cfg_wdata;
		cfg_next.allow_sleep_on_block = cfg_wdata.allow_sleep_on_block & deep_allowed;
	end

	// -------------------------------------------------------------------------
	// policy register
	// -------------------------------------------------------------------------

	// all policy bits come up cleared, the core stays awake on any stall
	always_ff @(posedge clk_always_on or negedge rst_n) begin
		if (!rst_n) begin
			cfg <= '0;
		end else if (cfg_wr) begin
			cfg <= cfg_next;
		end
	end

endmodule

`default_nettype wire

// File: logic/power_ctrl.sv
// power_ctrl: wake/sleep FSM driving the fabric power request, the clock enable and stall release

`default_nettype none

module power_ctrl (
	input  wire                           clk_always_on,
	input  wire                           rst_n,

	// policy from the register block
	input  wire power_pkg::power_cfg_t    cfg,

	// stall levels and the front end drain indication
	input  wire power_pkg::stall_status_t status,
	input  wire                           frontend_pwrdown_ok,

	// wake sources
	input  wire                           wfi_wakeup_req,
	input  wire                           block_wakeup_pulse,

	// four-phase pair to the fabric power switch
	// ack is assumed high coming out of reset, matching req
	output logic                          pwrup_req,
	input  wire                           pwrup_ack,

	// enable for the core clock gate, the gate may add one cycle of delay
	output logic                          clk_en,

	// one-cycle pulse that lets the stalled instruction move on
	output logic                          stall_release,

	// current FSM state, for observation only
	output power_pkg::power_state_t       state
);

	logic block_wakeup_req;
	logic any_stall;
	logic active_wake_req;
	logic deep_allowed;

	assign any_stall = status.sleeping_on_wfi | status.sleeping_on_block;

	// a wake source counts only while a stall it can end is held
	// a block stall also ends on an interrupt
	assign active_wake_req =
		(status.sleeping_on_block && (block_wakeup_req || wfi_wakeup_req)) ||
		(status.sleeping_on_wfi && wfi_wakeup_req);

	// block stalls go deep only when the policy says so
	assign deep_allowed = (cfg.allow_power_down || cfg.allow_sleep) &&
		(status.sleeping_on_wfi || cfg.allow_sleep_on_block);

	// -------------------------------------------------------------------------
	// wake/sleep FSM
	// -------------------------------------------------------------------------

	always_ff @(posedge clk_always_on or negedge rst_n) begin
		if (!rst_n) begin
			state         <= power_pkg::power_awake;
			pwrup_req     <= 1'b1;
			clk_en        <= 1'b1;
			stall_release <= 1'b0;
		end else begin
			// release is a single-cycle pulse unless set again below
			stall_release <= 1'b0;
			case (state)
				power_pkg::power_awake: begin
					if (!any_stall || stall_release) begin
						// nothing to do, or the released stall is leaving
						// the pipeline at the end of this cycle
						state <= power_pkg::power_awake;
					end else if (active_wake_req) begin
						// wake is already here, skip the deep states entirely
						stall_release <= 1'b1;
					end else if (deep_allowed && frontend_pwrdown_ok) begin
						// fetch is quiet, drop whatever the policy lets us drop
						pwrup_req <= !cfg.allow_power_down;
						clk_en    <= !cfg.allow_sleep;
						state     <= cfg.allow_power_down ?
							power_pkg::power_enter_asleep : power_pkg::power_asleep;
					end
					// otherwise hold the stall and stay awake, either the
					// policy forbids sleep or fetch has not drained yet
				end
				power_pkg::power_enter_asleep: begin
					// fabric confirms power down by lowering ack
					if (!pwrup_ack) begin
						state <= power_pkg::power_asleep;
					end
				end
				power_pkg::power_asleep: begin
					if (active_wake_req) begin
						pwrup_req <= 1'b1;
						clk_en    <= 1'b1;
						// clock-gate-only wakeups pass through here too,
						// which covers a gate cell with one cycle of delay
						state     <= power_pkg::power_enter_awake;
					end
				end
				power_pkg::power_enter_awake: begin
					// fabric confirms power up by raising ack
					// ack never fell if only the clock was gated
					if (pwrup_ack) begin
						state         <= power_pkg::power_awake;
						stall_release <= 1'b1;
					end
				end
				default: begin
					state <= power_pkg::power_awake;
				end
			endcase
		end
	end

	// -------------------------------------------------------------------------
	// sticky block wakeup
	// -------------------------------------------------------------------------

	// an unblock that arrives with no block stall pending is remembered,
	// so the next block stall falls straight through
	always_ff @(posedge clk_always_on or negedge rst_n) begin
		if (!rst_n) begin
			block_wakeup_req <= 1'b0;
		end else begin
			// a new pulse beats the clear, so an unblock landing on the
			// release cycle is not lost
			block_wakeup_req <= block_wakeup_pulse ||
				(block_wakeup_req && !(status.sleeping_on_block && stall_release));
		end
	end

endmodule

`default_nettype wire

// File: logic/power_pkg.sv
// power_pkg: shared types and default parameters for the sleep and wake controller

`default_nettype none

package power_pkg;

	// -------------------------------------------------------------------------
	// configuration and status
	// -------------------------------------------------------------------------

	// power policy as the core writes it
	// allow_sleep_on_block only matters when one of the other two bits is set
	typedef struct packed {
		logic allow_sleep_on_block;
		logic allow_power_down;
		logic allow_sleep;
	} power_cfg_t;

	// stall levels seen from the pipeline, never both set at the same time
	typedef struct packed {
		logic sleeping_on_block;
		logic sleeping_on_wfi;
	} stall_status_t;

	// wake/sleep FSM encoding
	// the two entering states wait on the fabric acknowledge
	typedef enum logic [1:0] {
		power_awake        = 2'h0,
		power_enter_asleep = 2'h1,
		power_asleep       = 2'h2,
		power_enter_awake  = 2'h3
	} power_state_t;

	// -------------------------------------------------------------------------
	// default parameter values
	// -------------------------------------------------------------------------

	localparam int unsigned default_num_irq = 8;
	// quiet fetch cycles before the front end counts as drained
	localparam int unsigned default_drain_cycles = 3;

endpackage

`default_nettype wire

// File: logic/sleep_subsys_top.sv
// sleep_subsys_top: sleep and wake subsystem, joining policy register, irq sync, stall tracker and FSM

`default_nettype none

module sleep_subsys_top #(
	parameter int unsigned num_irq      = power_pkg::default_num_irq,
	parameter int unsigned drain_cycles = power_pkg::default_drain_cycles
) (
	input  wire                           clk_always_on,
	input  wire                           rst_n,

	// policy register write port
	input  wire                           cfg_wr,
	input  wire power_pkg::power_cfg_t    cfg_wdata,
	output power_pkg::power_cfg_t         cfg_rdata,

	// interrupts
	input  wire [num_irq-1:0]             irq,
	input  wire [num_irq-1:0]             irq_mask,

	// pipeline side
	input  wire                           wfi_strobe,
	input  wire                           block_strobe,
	input  wire                           fetch_busy,
	input  wire                           block_wakeup_pulse,
	output power_pkg::stall_status_t      status,
	output logic                          stall_release,

	// fabric power pair and clock gate enable
	output logic                          pwrup_req,
	input  wire                           pwrup_ack,
	output logic                          clk_en,

	output power_pkg::power_state_t       power_state
);

	logic wfi_wakeup_req;
	logic frontend_pwrdown_ok;

	// -------------------------------------------------------------------------
	// blocks
	// -------------------------------------------------------------------------

	power_csr power_csr_i (
		.clk_always_on (clk_always_on),
		.rst_n         (rst_n),
		.cfg_wr        (cfg_wr),
		.cfg_wdata     (cfg_wdata),
		.cfg           (cfg_rdata)
	);

	irq_wake_sync #(
		.num_irq (num_irq)
	) irq_wake_sync_i (
		.clk_always_on  (clk_always_on),
		.rst_n          (rst_n),
		.irq            (irq),
		.irq_mask       (irq_mask),
		.wfi_wakeup_req (wfi_wakeup_req)
	);

	stall_tracker #(
		.drain_cycles (drain_cycles)
	) stall_tracker_i (
		.clk_always_on       (clk_always_on),
		.rst_n               (rst_n),
		.wfi_strobe          (wfi_strobe),
		.block_strobe        (block_strobe),
		.fetch_busy          (fetch_busy),
		.stall_release       (stall_release),
		.status              (status),
		.frontend_pwrdown_ok (frontend_pwrdown_ok)
	);

	// the registered policy feeds the FSM and the read port alike
	power_ctrl power_ctrl_i (
		.clk_always_on       (clk_always_on),
		.rst_n               (rst_n),
		.cfg                 (cfg_rdata),
		.status              (status),
		.frontend_pwrdown_ok (frontend_pwrdown_ok),
		.wfi_wakeup_req      (wfi_wakeup_req),
		.block_wakeup_pulse  (block_wakeup_pulse),
		.pwrup_req           (pwrup_req),
		.pwrup_ack           (pwrup_ack),
		.clk_en              (clk_en),
		.stall_release       (stall_release),
		.state               (power_state)
	);

endmodule

`default_nettype wire

// File: logic/stall_tracker.sv
// stall_tracker: WFI and block stall levels, plus the fetch drain counter for power-down safety

`default_nettype none

module stall_tracker #(
	parameter int unsigned drain_cycles = power_pkg::default_drain_cycles
) (
	input  wire                           clk_always_on,
	input  wire                           rst_n,

	// one-cycle strobes when a WFI or block instruction reaches the stall point
	input  wire                           wfi_strobe,
	input  wire                           block_strobe,
	// high while the fetch unit still has requests in flight
	input  wire                           fetch_busy,
	// one-cycle release from the FSM
	input  wire                           stall_release,

	output power_pkg::stall_status_t      status,
	output logic                          frontend_pwrdown_ok
);

	// counter must hold drain_cycles itself, and never be zero bits wide
	localparam int unsigned cnt_w = (drain_cycles < 1) ? 1 : $clog2(drain_cycles + 1);

	logic             any_stall;
	logic [cnt_w-1:0] quiet_cnt;
	logic             drained;

	assign any_stall = status.sleeping_on_wfi | status.sleeping_on_block;

	// -------------------------------------------------------------------------
	// stall levels
	// -------------------------------------------------------------------------

	// a strobe is dropped while any level is held, so the two stay exclusive
	// WFI wins if both strobes come together, which the pipeline should not do
	always_ff @(posedge clk_always_on or negedge rst_n) begin
		if (!rst_n) begin
			status <= '0;
		end else if (any_stall) begin
			// the held level drops at the end of the release cycle
			if (stall_release) begin
				status <= '0;
			end
		end else if (wfi_strobe) begin
			status.sleeping_on_wfi <= 1'b1;
		end else if (block_strobe) begin
			status.sleeping_on_block <= 1'b1;
		end
	end

	// -------------------------------------------------------------------------
	// fetch drain counter
	// -------------------------------------------------------------------------

	assign drained = (quiet_cnt == cnt_w'(drain_cycles));

	// counts consecutive quiet fetch cycles during a stall and saturates,
	// any fetch activity or the end of the stall starts it again
	always_ff @(posedge clk_always_on or negedge rst_n) begin
		if (!rst_n) begin
			quiet_cnt <= '0;
		end else if (fetch_busy || !any_stall) begin
			quiet_cnt <= '0;
		end else if (!drained) begin
			quiet_cnt <= quiet_cnt + 1'b1;
		end
	end

	// only meaningful while a stall is held
	assign frontend_pwrdown_ok = any_stall & drained;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the sleep subsystem testbench with Verilator, run it and look for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f sleep_subsys.f --top-module sleep_subsys_tb -o sleep_subsys_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/sleep_subsys_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** PASSED ***'; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: sleep_subsys.f
logic/power_pkg.sv
logic/power_csr.sv
logic/irq_wake_sync.sv
logic/stall_tracker.sv
logic/power_ctrl.sv
logic/sleep_subsys_top.sv
test/fabric_power_model.sv
test/sleep_subsys_tb.sv

// File: test/fabric_power_model.sv
// fabric_power_model: fabric power switch model that follows the power request after a fixed delay

`default_nettype none

module fabric_power_model #(
	parameter int unsigned delay_cycles = 4
) (
	input  wire  clk_always_on,
	input  wire  rst_n,
	input  wire  pwrup_req,
	output logic pwrup_ack
);

	timeunit 1ns;
	timeprecision 100ps;

	// cycles spent since the request and the acknowledge last disagreed
	int unsigned wait_cnt;

	// the switch comes out of reset powered, so ack starts high like req
	always @(posedge clk_always_on or negedge rst_n) begin
		if (!rst_n) begin
			pwrup_ack <= 1'b1;
			wait_cnt  <= 0;
		end else if (pwrup_req == pwrup_ack) begin
			wait_cnt <= 0;
		end else if (wait_cnt == delay_cycles - 1) begin
			// ack follows req delay_cycles edges after req moved
			pwrup_ack <= pwrup_req;
			wait_cnt  <= 0;
		end else begin
			wait_cnt <= wait_cnt + 1;
		end
	end

endmodule

`default_nettype wire

// File: test/sleep_subsys_tb.sv
// sleep_subsys_tb: testbench for the sleep and wake subsystem, checked by assertions

`default_nettype none

module sleep_subsys_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int unsigned num_irq      = 8;
	localparam int unsigned drain_cycles = 3;
	localparam int unsigned num_tests    = 6;
	localparam int unsigned test_cycles  = 200;
	localparam int unsigned clk_period   = 10;

	// selectors for the signals that wait_until can watch
	localparam int unsigned sel_release = 0;
	localparam int unsigned sel_clk_en  = 1;
	localparam int unsigned sel_req     = 2;
	localparam int unsigned sel_ack     = 3;
	localparam int unsigned sel_status  = 4;

	logic                     clk_always_on;
	logic                     rst_n;
	logic                     cfg_wr;
	power_pkg::power_cfg_t    cfg_wdata;
	power_pkg::power_cfg_t    cfg_rdata;
	logic [num_irq-1:0]       irq;
	logic [num_irq-1:0]       irq_mask;
	logic                     wfi_strobe;
	logic                     block_strobe;
	logic                     fetch_busy;
	logic                     block_wakeup_pulse;
	power_pkg::stall_status_t status;
	logic                     stall_release;
	logic                     pwrup_req;
	logic                     pwrup_ack;
	logic                     clk_en;
	power_pkg::power_state_t  power_state;
	string                    test_name;

	sleep_subsys_top #(
		.num_irq      (num_irq),
		.drain_cycles (drain_cycles)
	) sleep_subsys_top_i (
		.clk_always_on      (clk_always_on),
		.rst_n              (rst_n),
		.cfg_wr             (cfg_wr),
		.cfg_wdata          (cfg_wdata),
		.cfg_rdata          (cfg_rdata),
		.irq                (irq),
		.irq_mask           (irq_mask),
		.wfi_strobe         (wfi_strobe),
		.block_strobe       (block_strobe),
		.fetch_busy         (fetch_busy),
		.block_wakeup_pulse (block_wakeup_pulse),
		.status             (status),
		.stall_release      (stall_release),
		.pwrup_req          (pwrup_req),
		.pwrup_ack          (pwrup_ack),
		.clk_en             (clk_en),
		.power_state        (power_state)
	);

	fabric_power_model #(
		.delay_cycles (4)
	) fabric_power_model_i (
		.clk_always_on (clk_always_on),
		.rst_n         (rst_n),
		.pwrup_req     (pwrup_req),
		.pwrup_ack     (pwrup_ack)
	);

	initial clk_always_on = 1'b0;
	always #(clk_period / 2) clk_always_on = ~clk_always_on;

	// ------------------------------------------------------------------------
	// reference view of drain and interrupt wake
	// ------------------------------------------------------------------------

	logic [num_irq-1:0] irq_d1;
	logic [num_irq-1:0] irq_d2;
	int unsigned        quiet_run;
	logic               stall_held;
	logic               drained_ref;
	logic               irq_wake_ref;

	assign stall_held   = status.sleeping_on_wfi | status.sleeping_on_block;
	assign drained_ref  = stall_held && (quiet_run >= drain_cycles);
	// interrupts reach the FSM two edges late, then the mask applies
	assign irq_wake_ref = |(irq_d2 & irq_mask);

	always @(posedge clk_always_on or negedge rst_n) begin
		if (!rst_n) begin
			irq_d1    <= '0;
			irq_d2    <= '0;
			quiet_run <= 0;
		end else begin
			irq_d1 <= irq;
			irq_d2 <= irq_d1;
			if (fetch_busy || !stall_held) begin
				quiet_run <= 0;
			end else if (quiet_run < drain_cycles) begin
				quiet_run <= quiet_run + 1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// failure reporting and helpers
	// ------------------------------------------------------------------------

	task automatic stop_with_failure();
		$display("*** FAILED ***");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("ERROR [%s] %s: expected 0x%0h, actual 0x%0h", test_name, what,
			expected, actual);
		stop_with_failure();
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual == expected)
		else report_mismatch(what, expected, actual);
	endtask

	// inputs change and outputs are read 1 ns after the rising edge
	task automatic step();
		@(posedge clk_always_on);
		#1;
	endtask

	function automatic logic watched(input int unsigned sel);
		case (sel)
			sel_release: return stall_release;
			sel_clk_en:  return clk_en;
			sel_req:     return pwrup_req;
			sel_ack:     return pwrup_ack;
			default:     return stall_held;
		endcase
	endfunction

	task automatic wait_until(input int unsigned sel, input logic value,
		input int unsigned max_cycles, input string what);
		int unsigned n;
		n = 0;
		while (watched(sel) != value) begin
			if (n == max_cycles) begin
				$display("[%s] %s did not reach %0b within %0d cycles", test_name, what,
					value, max_cycles);
				stop_with_failure();
			end else begin
				step();
				n++;
			end
		end
	endtask

	function automatic power_pkg::power_cfg_t make_cfg(input logic sleep,
		input logic power_down, input logic sleep_on_block);
		power_pkg::power_cfg_t c;
		c.allow_sleep          = sleep;
		c.allow_power_down     = power_down;
		c.allow_sleep_on_block = sleep_on_block;
		return c;
	endfunction

	function automatic logic [num_irq-1:0] irq_bit(input int unsigned line);
		logic [num_irq-1:0] v;
		v       = '0;
		v[line] = 1'b1;
		return v;
	endfunction

	task automatic write_cfg(input power_pkg::power_cfg_t value);
		cfg_wdata = value;
		cfg_wr    = 1'b1;
		step();
		cfg_wr    = 1'b0;
	endtask

	task automatic strobe_wfi();
		wfi_strobe = 1'b1;
		step();
		wfi_strobe = 1'b0;
	endtask

	task automatic strobe_block();
		block_strobe = 1'b1;
		step();
		block_strobe = 1'b0;
	endtask

	task automatic pulse_unblock();
		block_wakeup_pulse = 1'b1;
		step();
		block_wakeup_pulse = 1'b0;
	endtask

	// random fetch activity, then a quiet front end
	task automatic fetch_noise(input int unsigned cycles);
		repeat (cycles) begin
			fetch_busy = 1'($urandom_range(1, 0));
			step();
		end
		fetch_busy = 1'b0;
	endtask

	// drop all interrupts and let the synchronizer empty
	task automatic flush_irq();
		irq = '0;
		repeat (4) step();
	endtask

	// ------------------------------------------------------------------------
	// protocol assertions
	// ------------------------------------------------------------------------

	release_single: assert property (@(posedge clk_always_on) disable iff (!rst_n)
		stall_release |-> !$past(stall_release))
		else report_mismatch("stall_release in the previous cycle", 32'd0, 32'd1);

	release_with_stall: assert property (@(posedge clk_always_on) disable iff (!rst_n)
		stall_release |-> stall_held)
		else report_mismatch("stall held at stall_release", 32'd1, 32'd0);

	release_req_ack: assert property (@(posedge clk_always_on) disable iff (!rst_n)
		stall_release |-> (pwrup_req == pwrup_ack))
		else report_mismatch("pwrup_ack at stall_release", 32'($sampled(pwrup_req)),
			32'($sampled(pwrup_ack)));

	release_clk_on: assert property (@(posedge clk_always_on) disable iff (!rst_n)
		stall_release |-> clk_en)
		else report_mismatch("clk_en at stall_release", 32'd1, 32'd0);

	// four-phase order on the fabric pair
	req_fall_ack_high: assert property (@(posedge clk_always_on) disable iff (!rst_n)
		$fell(pwrup_req) |-> $past(pwrup_ack))
		else report_mismatch("pwrup_ack before pwrup_req fell", 32'd1, 32'd0);

	req_rise_ack_low: assert property (@(posedge clk_always_on) disable iff (!rst_n)
		$rose(pwrup_req) |-> !$past(pwrup_ack))
		else report_mismatch("pwrup_ack before pwrup_req rose", 32'd0, 32'd1);

	req_fall_drained: assert property (@(posedge clk_always_on) disable iff (!rst_n)
		$fell(pwrup_req) |-> $past(drained_ref))
		else report_mismatch("front end drained before pwrup_req fell", 32'd1, 32'd0);

	clk_fall_drained: assert property (@(posedge clk_always_on) disable iff (!rst_n)
		$fell(clk_en) |-> $past(drained_ref))
		else report_mismatch("front end drained before clk_en fell", 32'd1, 32'd0);

	req_rise_wake: assert property (@(posedge clk_always_on) disable iff (!rst_n)
		$rose(pwrup_req) |-> $past(irq_wake_ref))
		else report_mismatch("wake request before pwrup_req rose", 32'd1, 32'd0);

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------

	initial begin
		#(num_tests * test_cycles * clk_period);
		$display("watchdog expired, the run took longer than %0d cycles per test",
			test_cycles);
		stop_with_failure();
	end

	initial begin
		int unsigned en_line;
		int unsigned dis_line;
		int unsigned releases;
		void'($urandom(32'h497d_6947));
		test_name          = "reset";
		rst_n              = 1'b0;
		cfg_wr             = 1'b0;
		cfg_wdata          = '0;
		irq                = '0;
		irq_mask           = '0;
		wfi_strobe         = 1'b0;
		block_strobe       = 1'b0;
		fetch_busy         = 1'b0;
		block_wakeup_pulse = 1'b0;
		repeat (2) @(posedge clk_always_on);
		#1;
		rst_n = 1'b1;
		check_value("pwrup_req", 32'd1, 32'(pwrup_req));
		check_value("clk_en", 32'd1, 32'(clk_en));
		check_value("stall_release", 32'd0, 32'(stall_release));
		check_value("power_state", 32'(power_pkg::power_awake), 32'(power_state));
		check_value("cfg_rdata", 32'd0, 32'(cfg_rdata));
		check_value("status", 32'd0, 32'(status));

		// gate the clock only, a masked line must leave the core asleep
		test_name = "clock gating";
		write_cfg(make_cfg(1'b1, 1'b0, 1'b0));
		check_value("cfg_rdata", 32'(make_cfg(1'b1, 1'b0, 1'b0)), 32'(cfg_rdata));
		en_line  = $urandom_range(num_irq - 1, 0);
		dis_line = (en_line + $urandom_range(num_irq - 1, 1)) % num_irq;
		irq_mask = ~irq_bit(dis_line);
		strobe_wfi();
		fetch_noise(6);
		wait_until(sel_clk_en, 1'b0, 20, "clk_en");
		check_value("pwrup_req while clock gated", 32'd1, 32'(pwrup_req));
		irq = irq_bit(dis_line);
		repeat (6) step();
		check_value("clk_en with masked irq", 32'd0, 32'(clk_en));
		irq = irq | irq_bit(en_line);
		wait_until(sel_release, 1'b1, 10, "stall_release");
		step();
		check_value("status after release", 32'd0, 32'(status));
		flush_irq();

		test_name = "power down";
		write_cfg(make_cfg(1'b1, 1'b1, 1'b0));
		check_value("cfg_rdata", 32'(make_cfg(1'b1, 1'b1, 1'b0)), 32'(cfg_rdata));
		en_line  = $urandom_range(num_irq - 1, 0);
		irq_mask = irq_bit(en_line) | num_irq'($urandom);
		strobe_wfi();
		fetch_noise(5);
		wait_until(sel_req, 1'b0, 20, "pwrup_req");
		check_value("clk_en at power down", 32'd0, 32'(clk_en));
		wait_until(sel_ack, 1'b0, 10, "pwrup_ack");
		repeat (3) step();
		check_value("power_state", 32'(power_pkg::power_asleep), 32'(power_state));
		check_value("pwrup_req before wake", 32'd0, 32'(pwrup_req));
		irq = irq_bit(en_line);
		wait_until(sel_req, 1'b1, 10, "pwrup_req");
		wait_until(sel_release, 1'b1, 10, "stall_release");
		step();
		check_value("status after release", 32'd0, 32'(status));
		flush_irq();

		// wake already pending when the stall shows up
		test_name = "fall-through";
		en_line  = $urandom_range(num_irq - 1, 0);
		irq_mask = irq_bit(en_line);
		irq      = irq_bit(en_line);
		repeat (3) step();
		strobe_wfi();
		wait_until(sel_status, 1'b1, 4, "stall status");
		step();
		check_value("stall_release after status", 32'd1, 32'(stall_release));
		check_value("pwrup_req", 32'd1, 32'(pwrup_req));
		check_value("clk_en", 32'd1, 32'(clk_en));
		flush_irq();

		test_name = "sticky unblock";
		write_cfg(make_cfg(1'b0, 1'b0, 1'b1));
		check_value("cfg_rdata, sleep-on-block alone", 32'd0, 32'(cfg_rdata));
		write_cfg(make_cfg(1'b1, 1'b0, 1'b0));
		pulse_unblock();
		repeat (3) step();
		strobe_block();
		wait_until(sel_status, 1'b1, 4, "stall status");
		step();
		check_value("stall_release after status", 32'd1, 32'(stall_release));
		step();
		check_value("status after release", 32'd0, 32'(status));
		// no sleep-on-block, so this stall is held with the clock running
		strobe_block();
		repeat (12) begin
			step();
			check_value("clk_en on block stall", 32'd1, 32'(clk_en));
			check_value("stall_release on block stall", 32'd0, 32'(stall_release));
		end
		check_value("sleeping_on_block", 32'd1, 32'(status.sleeping_on_block));
		check_value("power_state", 32'(power_pkg::power_awake), 32'(power_state));
		pulse_unblock();
		wait_until(sel_release, 1'b1, 4, "stall_release");
		step();
		check_value("status after release", 32'd0, 32'(status));

		// a strobe held high gives two stalls, each with one release
		test_name = "single release";
		irq_mask   = irq_bit(en_line);
		irq        = irq_bit(en_line);
		repeat (3) step();
		wfi_strobe = 1'b1;
		releases   = 0;
		for (int i = 0; i < 8; i++) begin
			step();
			if (i == 3) begin
				wfi_strobe = 1'b0;
			end
			if (stall_release) begin
				releases++;
			end
		end
		check_value("stall_release pulses", 32'd2, 32'(releases));
		flush_irq();

		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
